// File: Bender.yml
package:
  name: tag_cfg

sources:
  - files:
      - rtl/tag_cfg_pkg.sv
      - rtl/tag_master.sv
      - rtl/tag_client.sv
      - rtl/dmc_cfg_decoder.sv
      - rtl/tag_cfg_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tag_cfg_tb.sv

// File: rtl/dmc_cfg_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module dmc_cfg_decoder
  import tag_cfg_pkg::*;
(
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic [TAG_NUM_CLIENTS-1:0][TAG_PAYLOAD_W-1:0] cfg_bytes_i,
  input  logic [TAG_NUM_CLIENTS-1:0]                    cfg_new_i,
  output dmc_timing_s                                   dmc_cfg_o,
  output logic                                          dmc_sys_reset_o,
  output logic                                          cfg_valid_o
);

  dmc_timing_s                cfg_map;
  logic [TAG_NUM_CLIENTS-1:0] rcvd_q;
  logic [TAG_NUM_CLIENTS-1:0] rcvd_d;
  logic                       cfg_update;

  assign cfg_update = |cfg_new_i;
  assign rcvd_d     = rcvd_q | cfg_new_i;

  //////////////////////////////
  // byte to field map
  //////////////////////////////

  always_comb
  begin
    cfg_map.trefi        = {cfg_bytes_i[1], cfg_bytes_i[0]};
    cfg_map.tmrd         = cfg_bytes_i[2][3:0];
    cfg_map.trfc         = cfg_bytes_i[2][7:4];
    cfg_map.trc          = cfg_bytes_i[3][3:0];
    cfg_map.trp          = cfg_bytes_i[3][7:4];
    cfg_map.tras         = cfg_bytes_i[4][3:0];
    cfg_map.trrd         = cfg_bytes_i[4][7:4];
    cfg_map.trcd         = cfg_bytes_i[5][3:0];
    cfg_map.twr          = cfg_bytes_i[5][7:4];
    cfg_map.twtr         = cfg_bytes_i[6][3:0];
    cfg_map.trtp         = cfg_bytes_i[6][7:4];
    // byte 7 upper nibble unused
    cfg_map.tcas         = cfg_bytes_i[7][3:0];
    cfg_map.col_width    = cfg_bytes_i[8][3:0];
    cfg_map.row_width    = cfg_bytes_i[8][7:4];
    cfg_map.bank_width   = cfg_bytes_i[9][1:0];
    cfg_map.bank_pos     = cfg_bytes_i[9][7:2];
    cfg_map.dqs_sel_cal  = cfg_bytes_i[10][1:0];
    cfg_map.init_cmd_cnt = cfg_bytes_i[10][5:2];
  end

  //////////////////////////////
  // output registers
  //////////////////////////////

  // whole record reloads on any client update
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      dmc_cfg_o       <= '0;
      dmc_sys_reset_o <= 1'b0;
    end
    else if (cfg_update)
    begin
      dmc_cfg_o       <= cfg_map;
      dmc_sys_reset_o <= cfg_bytes_i[TAG_CFG_RESET_BYTE][0];
    end
  end

  // complete once every client has been written at least once
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      rcvd_q      <= '0;
      cfg_valid_o <= 1'b0;
    end
    else
    begin
      rcvd_q      <= rcvd_d;
      cfg_valid_o <= cfg_valid_o | (&rcvd_d);
    end
  end

endmodule

`default_nettype wire

// File: rtl/tag_cfg_pkg.sv
`default_nettype none

package tag_cfg_pkg;

  //////////////////////////////
  // frame geometry
  //////////////////////////////

  localparam int TAG_NUM_CLIENTS    = 12;
  localparam int TAG_ID_W           = 4;
  localparam int TAG_PAYLOAD_W      = 8;
  // counter covers both id and payload phases
  localparam int TAG_CNT_W          = $clog2(TAG_PAYLOAD_W);
  // byte 11 bit 0 drives the controller reset
  localparam int TAG_CFG_RESET_BYTE = 11;

  //////////////////////////////
  // master to client line
  //////////////////////////////

  typedef struct packed {
    logic shift;
    logic data;
    logic commit;
  } tag_line_s;

  typedef enum logic [1:0] {
    TAG_IDLE,
    TAG_ID,
    TAG_PAYLOAD
  } tag_state_e;

  //////////////////////////////
  // controller timing record
  //////////////////////////////

  typedef struct packed {
    logic [15:0] trefi;
    logic [3:0]  tmrd;
    logic [3:0]  trfc;
    logic [3:0]  trc;
    logic [3:0]  trp;
    logic [3:0]  tras;
    logic [3:0]  trrd;
    logic [3:0]  trcd;
    logic [3:0]  twr;
    logic [3:0]  twtr;
    logic [3:0]  trtp;
    logic [3:0]  tcas;
    logic [3:0]  col_width;
    logic [3:0]  row_width;
    logic [1:0]  bank_width;
    logic [5:0]  bank_pos;
    logic [1:0]  dqs_sel_cal;
    logic [3:0]  init_cmd_cnt;
  } dmc_timing_s;

endpackage

`default_nettype wire

// File: rtl/tag_cfg_top.sv
`timescale 1ns/100ps
`default_nettype none

module tag_cfg_top
  import tag_cfg_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        tag_en_i,
  input  logic        tag_data_i,
  output dmc_timing_s dmc_cfg_o,
  output logic        dmc_sys_reset_o,
  output logic        cfg_valid_o
);

  tag_line_s [TAG_NUM_CLIENTS-1:0]                    tag_lines;
  logic      [TAG_NUM_CLIENTS-1:0][TAG_PAYLOAD_W-1:0] cfg_bytes;
  logic      [TAG_NUM_CLIENTS-1:0]                    cfg_new;

  //////////////////////////////
  // tag master
  //////////////////////////////

  tag_master tag_master_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .tag_en_i    (tag_en_i),
    .tag_data_i  (tag_data_i),
    .tag_lines_o (tag_lines)
  );

  //////////////////////////////
  // one client per config byte
  //////////////////////////////

  for (genvar i = 0; i < TAG_NUM_CLIENTS; i++)
  begin : gen_cfg_client
    tag_client tag_client_inst (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .tag_line_i (tag_lines[i]),
      .data_o     (cfg_bytes[i]),
      .new_o      (cfg_new[i])
    );
  end

  //////////////////////////////
  // controller config decode
  //////////////////////////////

  dmc_cfg_decoder dmc_cfg_decoder_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cfg_bytes_i     (cfg_bytes),
    .cfg_new_i       (cfg_new),
    .dmc_cfg_o       (dmc_cfg_o),
    .dmc_sys_reset_o (dmc_sys_reset_o),
    .cfg_valid_o     (cfg_valid_o)
  );

endmodule

`default_nettype wire

// File: rtl/tag_client.sv
`timescale 1ns/100ps
`default_nettype none

module tag_client
  import tag_cfg_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  tag_line_s                tag_line_i,
  output logic [TAG_PAYLOAD_W-1:0] data_o,
  output logic                     new_o
);

  logic [TAG_PAYLOAD_W-1:0] shift_q;
  logic [TAG_PAYLOAD_W-1:0] shift_d;

  // last bit and commit share a cycle, so commit takes shift_d
  assign shift_d = tag_line_i.shift ? {shift_q[TAG_PAYLOAD_W-2:0], tag_line_i.data}
                                    : shift_q;

  always_ff @(posedge clk_i)
  begin
    shift_q <= shift_d;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      data_o <= '0;
      new_o  <= 1'b0;
    end
    else
    begin
      new_o <= tag_line_i.commit;
      if (tag_line_i.commit)
        data_o <= shift_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/tag_master.sv
`timescale 1ns/100ps
`default_nettype none

module tag_master
  import tag_cfg_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             tag_en_i,
  input  logic                             tag_data_i,
  output tag_line_s [TAG_NUM_CLIENTS-1:0]  tag_lines_o
);

  tag_state_e                 state_q;
  tag_state_e                 state_d;
  logic [TAG_CNT_W-1:0]       bit_cnt_q;
  logic [TAG_CNT_W-1:0]       bit_cnt_d;
  logic [TAG_ID_W-1:0]        id_q;
  logic [TAG_NUM_CLIENTS-1:0] client_sel;
  logic                       id_bit;
  logic                       payload_bit;
  logic                       last_bit;

  // gaps (tag_en_i low) freeze everything
  assign id_bit      = tag_en_i && (state_q == TAG_ID);
  assign payload_bit = tag_en_i && (state_q == TAG_PAYLOAD);
  assign last_bit    = payload_bit && (bit_cnt_q == TAG_CNT_W'(TAG_PAYLOAD_W - 1));

  //////////////////////////////
  // frame FSM
  //////////////////////////////

  always_comb
  begin
    state_d   = state_q;
    bit_cnt_d = bit_cnt_q;
    if (tag_en_i)
    begin
      case (state_q)
        TAG_IDLE:
        begin
          // zeros between frames are idle fill
          bit_cnt_d = '0;
          if (tag_data_i)
            state_d = TAG_ID;
        end
        TAG_ID:
        begin
          if (bit_cnt_q == TAG_CNT_W'(TAG_ID_W - 1))
          begin
            state_d   = TAG_PAYLOAD;
            bit_cnt_d = '0;
          end
          else
            bit_cnt_d = bit_cnt_q + 1'b1;
        end
        TAG_PAYLOAD:
        begin
          if (last_bit)
          begin
            state_d   = TAG_IDLE;
            bit_cnt_d = '0;
          end
          else
            bit_cnt_d = bit_cnt_q + 1'b1;
        end
        default:
        begin
          state_d   = TAG_IDLE;
          bit_cnt_d = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q   <= TAG_IDLE;
      bit_cnt_q <= '0;
    end
    else
    begin
      state_q   <= state_d;
      bit_cnt_q <= bit_cnt_d;
    end
  end

  // id arrives msb first
  always_ff @(posedge clk_i)
  begin
    if (id_bit)
      id_q <= {id_q[TAG_ID_W-2:0], tag_data_i};
  end

  //////////////////////////////
  // client line drive
  //////////////////////////////

  // ids past the last client match nothing
  always_comb
  begin
    client_sel = '0;
    for (int i = 0; i < TAG_NUM_CLIENTS; i++)
      client_sel[i] = (id_q == TAG_ID_W'(i));
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      tag_lines_o <= '0;
    else
    begin
      for (int i = 0; i < TAG_NUM_CLIENTS; i++)
      begin
        tag_lines_o[i].shift  <= payload_bit && client_sel[i];
        tag_lines_o[i].data   <= payload_bit && client_sel[i] && tag_data_i;
        tag_lines_o[i].commit <= last_bit && client_sel[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verification
rtl/tag_cfg_pkg.sv
rtl/tag_master.sv
rtl/tag_client.sv
rtl/dmc_cfg_decoder.sv
rtl/tag_cfg_top.sv
verification/tag_cfg_tb.sv

// File: verification/tag_cfg_tests.svh
`ifndef TAG_CFG_TESTS_SVH
`define TAG_CFG_TESTS_SVH

//////////////////////////////
// reference model
//////////////////////////////

logic [TAG_PAYLOAD_W-1:0]   exp_bytes [TAG_NUM_CLIENTS];
logic [TAG_NUM_CLIENTS-1:0] exp_rcvd;
int                         order [TAG_NUM_CLIENTS];

task automatic model_clear();
  for (int i = 0; i < TAG_NUM_CLIENTS; i++)
    exp_bytes[i] = '0;
  exp_rcvd = '0;
endtask

// field map as listed for the timing record
function automatic dmc_timing_s expected_cfg();
  dmc_timing_s cfg;
  cfg.trefi        = {exp_bytes[1], exp_bytes[0]};
  cfg.tmrd         = exp_bytes[2][3:0];
  cfg.trfc         = exp_bytes[2][7:4];
  cfg.trc          = exp_bytes[3][3:0];
  cfg.trp          = exp_bytes[3][7:4];
  cfg.tras         = exp_bytes[4][3:0];
  cfg.trrd         = exp_bytes[4][7:4];
  cfg.trcd         = exp_bytes[5][3:0];
  cfg.twr          = exp_bytes[5][7:4];
  cfg.twtr         = exp_bytes[6][3:0];
  cfg.trtp         = exp_bytes[6][7:4];
  cfg.tcas         = exp_bytes[7][3:0];
  cfg.col_width    = exp_bytes[8][3:0];
  cfg.row_width    = exp_bytes[8][7:4];
  cfg.bank_width   = exp_bytes[9][1:0];
  cfg.bank_pos     = exp_bytes[9][7:2];
  cfg.dqs_sel_cal  = exp_bytes[10][1:0];
  cfg.init_cmd_cnt = exp_bytes[10][5:2];
  return cfg;
endfunction

function automatic logic [TAG_PAYLOAD_W-1:0] rand_byte();
  int unsigned r;
  r = $urandom;
  return r[TAG_PAYLOAD_W-1:0];
endfunction

task automatic shuffle_order();
  int j;
  int tmp;
  for (int i = 0; i < TAG_NUM_CLIENTS; i++)
    order[i] = i;
  for (int i = TAG_NUM_CLIENTS - 1; i > 0; i--)
  begin
    j        = $urandom_range(i, 0);
    tmp      = order[i];
    order[i] = order[j];
    order[j] = tmp;
  end
endtask

//////////////////////////////
// stimulus and checking
//////////////////////////////

task automatic apply_reset();
  @(posedge clk);
  rst_n  <= 1'b0;
  tag_en <= 1'b0;
  repeat (RESET_CYCLES) @(posedge clk);
  rst_n <= 1'b1;
  model_clear();
endtask

// start bit, id msb first, payload msb first; gap cycles carry junk data
task automatic send_frame(input logic [TAG_ID_W-1:0] id,
                          input logic [TAG_PAYLOAD_W-1:0] payload,
                          input bit with_gaps);
  logic [TAG_ID_W+TAG_PAYLOAD_W:0] frame;
  int                              gaps;
  int unsigned                     junk;
  frame = {1'b1, id, payload};
  for (int i = TAG_ID_W + TAG_PAYLOAD_W; i >= 0; i--)
  begin
    gaps = with_gaps ? $urandom_range(3, 0) : 0;
    repeat (gaps)
    begin
      junk = $urandom;
      @(posedge clk);
      tag_en   <= 1'b0;
      tag_data <= junk[0];
    end
    @(posedge clk);
    tag_en   <= 1'b1;
    tag_data <= frame[i];
  end
  @(posedge clk);
  tag_en   <= 1'b0;
  tag_data <= 1'b0;
  if (int'(id) < TAG_NUM_CLIENTS)
  begin
    exp_bytes[id] = payload;
    exp_rcvd[id]  = 1'b1;
  end
endtask

task automatic check_outputs(input string test_name);
  dmc_timing_s exp_cfg;
  logic        exp_reset;
  logic        exp_valid;
  exp_cfg   = expected_cfg();
  exp_reset = exp_bytes[TAG_CFG_RESET_BYTE][0];
  exp_valid = &exp_rcvd;
  assert (dmc_cfg === exp_cfg)
  else
  begin
    $display("[FAIL] %s dmc_cfg_o expected %h actual %h", test_name, exp_cfg, dmc_cfg);
    cfg_errors++;
  end
  assert (dmc_sys_reset === exp_reset)
  else
  begin
    $display("[FAIL] %s dmc_sys_reset_o expected %b actual %b",
             test_name, exp_reset, dmc_sys_reset);
    reset_errors++;
  end
  assert (cfg_valid === exp_valid)
  else
  begin
    $display("[FAIL] %s cfg_valid_o expected %b actual %b", test_name, exp_valid, cfg_valid);
    valid_errors++;
  end
endtask

// outputs settle two edges after the last payload bit
task automatic wait_and_check(input string test_name);
  repeat (2) @(posedge clk);
  @(negedge clk);
  check_outputs(test_name);
endtask

//////////////////////////////
// directed tests
//////////////////////////////

task automatic test_reset_state();
  @(negedge clk);
  check_outputs("reset_state");
endtask

task automatic test_single_byte();
  send_frame(4'd2, 8'hA7, 1'b0);
  wait_and_check("single_byte");
endtask

task automatic test_full_config();
  logic [TAG_ID_W-1:0] id;
  apply_reset();
  shuffle_order();
  for (int n = 0; n < TAG_NUM_CLIENTS; n++)
  begin
    id = order[n][TAG_ID_W-1:0];
    send_frame(id, rand_byte(), 1'b0);
    wait_and_check("full_config");
  end
endtask

task automatic test_overwrite_gaps();
  logic [TAG_ID_W-1:0] id;
  shuffle_order();
  for (int n = 0; n < TAG_NUM_CLIENTS; n++)
  begin
    id = order[n][TAG_ID_W-1:0];
    send_frame(id, rand_byte(), 1'b1);
    wait_and_check("overwrite_gaps");
  end
  // back to back on one client, second value must stick
  send_frame(4'd0, rand_byte(), 1'b1);
  send_frame(4'd0, rand_byte(), 1'b1);
  wait_and_check("overwrite_gaps");
endtask

task automatic test_unused_ids();
  logic [TAG_ID_W-1:0] id;
  for (int n = TAG_NUM_CLIENTS; n < (1 << TAG_ID_W); n++)
  begin
    id = n[TAG_ID_W-1:0];
    send_frame(id, rand_byte(), 1'b0);
    wait_and_check("unused_ids");
  end
  send_frame(4'd15, rand_byte(), 1'b0);
  send_frame(4'd5, rand_byte(), 1'b0);
  wait_and_check("unused_ids");
endtask

task automatic test_controller_reset();
  logic [TAG_ID_W-1:0] rst_id;
  rst_id = TAG_CFG_RESET_BYTE[TAG_ID_W-1:0];
  send_frame(rst_id, 8'h01, 1'b0);
  wait_and_check("controller_reset");
  send_frame(rst_id, 8'hFE, 1'b1);
  wait_and_check("controller_reset");
  send_frame(rst_id, 8'hFF, 1'b0);
  wait_and_check("controller_reset");
  send_frame(rst_id, 8'h00, 1'b0);
  wait_and_check("controller_reset");
endtask

`endif

// File: verification/tag_cfg_tb.sv
`timescale 1ns/100ps
`default_nettype none

module tag_cfg_tb
  import tag_cfg_pkg::*;
();

  localparam int unsigned RAND_SEED = 77968;
  localparam int          RESET_CYCLES = 16;
  // about 40 frames of up to 52 cycles each, plus reset and margin
  localparam int          TIMEOUT_CYCLES = 4000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        tag_en;
  logic        tag_data;
  dmc_timing_s dmc_cfg;
  logic        dmc_sys_reset;
  logic        cfg_valid;

  int          cycle_cnt = 0;
  int          cfg_errors = 0;
  int          reset_errors = 0;
  int          valid_errors = 0;

  tag_cfg_top tag_cfg_top_inst (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .tag_en_i        (tag_en),
    .tag_data_i      (tag_data),
    .dmc_cfg_o       (dmc_cfg),
    .dmc_sys_reset_o (dmc_sys_reset),
    .cfg_valid_o     (cfg_valid)
  );

  always #2 clk = ~clk;

  //////////////////////////////
  // run limit
  //////////////////////////////

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
      print_counts();
      $display("Checks failed");
      $finish;
    end
  end

  task automatic print_counts();
    $display("error counts: dmc_cfg_o %0d, dmc_sys_reset_o %0d, cfg_valid_o %0d, total %0d",
             cfg_errors, reset_errors, valid_errors,
             cfg_errors + reset_errors + valid_errors);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial
  begin
    rst_n    = 1'b0;
    tag_en   = 1'b0;
    tag_data = 1'b0;
    void'($urandom(RAND_SEED));
    apply_reset();
    test_reset_state();
    test_single_byte();
    test_full_config();
    test_overwrite_gaps();
    test_unused_ids();
    test_controller_reset();
    repeat (4) @(posedge clk);
    print_counts();
    if (cfg_errors + reset_errors + valid_errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  `include "tag_cfg_tests.svh"

endmodule

`default_nettype wire
